/* design/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define CPU_WORD_W 16

// General registers
`define CPU_NREGS 4

// Register index width
`define CPU_REG_W 2

// Immediate field width
`define CPU_IMM_W 8

`endif

/* design/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [`CPU_REG_W-1:0] regIdx_t;
	typedef logic [3:0] opcode_t;
	typedef logic [`CPU_IMM_W-1:0] imm_t;
	typedef logic [1:0] wbSel_t;

	typedef enum logic {
		FETCH,
		EXEC
	} phase_t;

	// Write-back sources
	localparam wbSel_t WB_ALU = 2'd0;
	localparam wbSel_t WB_IMM = 2'd1;
	localparam wbSel_t WB_MEM = 2'd2;

	localparam opcode_t OP_ADD = 4'h0;
	localparam opcode_t OP_SUB = 4'h1;
	localparam opcode_t OP_AND = 4'h2;
	localparam opcode_t OP_OR  = 4'h3;
	localparam opcode_t OP_XOR = 4'h4;
	localparam opcode_t OP_SHL = 4'h5;
	localparam opcode_t OP_SHR = 4'h6;
	localparam opcode_t OP_MOV = 4'h7;
	localparam opcode_t OP_LDI = 4'h8;
	localparam opcode_t OP_LD  = 4'h9;
	localparam opcode_t OP_ST  = 4'hA;
	localparam opcode_t OP_LDA = 4'hB;
	localparam opcode_t OP_STA = 4'hC;
	localparam opcode_t OP_JMP = 4'hD;
	localparam opcode_t OP_JZ  = 4'hE;
	localparam opcode_t OP_JC  = 4'hF;

endpackage

/* design/instrDecoder.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module instrDecoder
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input word_t dataIn,
	input logic cFlag,
	input logic zFlag,
	input word_t srcData,
	output phase_t phase,
	output word_t pc,
	output regIdx_t regDst,
	output regIdx_t regSrc,
	output logic regWe,
	output logic flagWe,
	output opcode_t aluOp,
	output wbSel_t wbSel,
	output logic memWrite,
	output logic addrFromDst,
	output logic addrFromSrc,
	output logic memRead,
	output imm_t imm
);

	word_t instr;
	opcode_t opcode;
	word_t immAddr;
	word_t pcInc;
	word_t nextPc;

	// Field split of the latched instruction
	assign opcode = opcode_t'(instr[15:12]);
	assign regDst = regIdx_t'(instr[11:10]);
	assign regSrc = regIdx_t'(instr[9:8]);
	assign imm = imm_t'(instr[7:0]);
	assign aluOp = opcode;

	assign immAddr = {{(`CPU_WORD_W-`CPU_IMM_W){1'b0}}, imm};
	assign pcInc = pc + word_t'(1);

	// Two-phase sequencer
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= FETCH;
			pc <= '0;
		end else if (phase == FETCH) begin
			phase <= EXEC;
		end else begin
			phase <= FETCH;
			pc <= nextPc;
		end
	end

	// Instruction latch, loaded at the end of fetch
	always_ff @(posedge clk) begin
		if (phase == FETCH)
			instr <= dataIn;
	end

	// Branch decision on the flags held before this edge
	always_comb begin
		case (opcode)
			OP_JMP: nextPc = instr[10] ? srcData : immAddr;
			OP_JZ: nextPc = zFlag ? immAddr : pcInc;
			OP_JC: nextPc = cFlag ? immAddr : pcInc;
			default: nextPc = pcInc;
		endcase
	end

	// Control decode, active in EXEC only
	always_comb begin
		regWe = 1'b0;
		flagWe = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		addrFromDst = 1'b0;
		addrFromSrc = 1'b0;
		wbSel = WB_ALU;
		if (phase == EXEC) begin
			case (opcode)
				OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR: begin
					regWe = 1'b1;
					flagWe = 1'b1;
				end
				// MOV passes the source through the ALU
				OP_MOV: regWe = 1'b1;
				OP_LDI: begin
					regWe = 1'b1;
					wbSel = WB_IMM;
				end
				OP_LD: begin
					regWe = 1'b1;
					memRead = 1'b1;
					addrFromSrc = 1'b1;
					wbSel = WB_MEM;
				end
				OP_LDA: begin
					regWe = 1'b1;
					memRead = 1'b1;
					wbSel = WB_MEM;
				end
				OP_ST: begin
					memWrite = 1'b1;
					addrFromDst = 1'b1;
				end
				OP_STA: memWrite = 1'b1;
				default: ;
			endcase
		end
	end

endmodule

/* design/registerFile.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module registerFile
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic regWe,
	input regIdx_t regDst,
	input regIdx_t regSrc,
	input word_t wbData,
	output word_t dstData,
	output word_t srcData
);

	word_t regs [`CPU_NREGS];

	// Write port
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (regWe) begin
			regs[regDst] <= wbData;
		end
	end

	// Asynchronous read ports
	assign dstData = regs[regDst];
	assign srcData = regs[regSrc];

endmodule

/* design/alu.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module alu
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input opcode_t aluOp,
	input logic flagWe,
	input word_t dstData,
	input word_t srcData,
	output word_t aluOut,
	output logic cFlag,
	output logic zFlag
);

	logic [`CPU_WORD_W:0] wide;
	logic carryNext;

	always_comb begin
		wide = '0;
		carryNext = 1'b0;
		aluOut = srcData;
		case (aluOp)
			OP_ADD: begin
				wide = {1'b0, dstData} + {1'b0, srcData};
				aluOut = wide[`CPU_WORD_W-1:0];
				carryNext = wide[`CPU_WORD_W];
			end
			// Top bit set on borrow
			OP_SUB: begin
				wide = {1'b0, dstData} - {1'b0, srcData};
				aluOut = wide[`CPU_WORD_W-1:0];
				carryNext = wide[`CPU_WORD_W];
			end
			OP_AND: aluOut = dstData & srcData;
			OP_OR: aluOut = dstData | srcData;
			OP_XOR: aluOut = dstData ^ srcData;
			OP_SHL: begin
				aluOut = dstData << 1;
				carryNext = dstData[`CPU_WORD_W-1];
			end
			OP_SHR: begin
				aluOut = dstData >> 1;
				carryNext = dstData[0];
			end
			OP_MOV: aluOut = srcData;
			default: aluOut = srcData;
		endcase
	end

	// Flags change only on arithmetic and logic ops
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagWe) begin
			cFlag <= carryNext;
			zFlag <= (aluOut == '0);
		end
	end

endmodule

/* design/memPort.sv */
`timescale 1ns/100ps

`include "cpu_macros.svh"

module memPort
	import cpu_pkg::*;
(
	input phase_t phase,
	input word_t pc,
	input imm_t imm,
	input logic memRead,
	input logic memWrite,
	input logic addrFromDst,
	input logic addrFromSrc,
	input wbSel_t wbSel,
	input word_t dstData,
	input word_t srcData,
	input word_t aluOut,
	input word_t dataIn,
	output word_t addrBus,
	output word_t dataOut,
	output word_t wbData,
	output logic memWe
);

	word_t immWord;
	word_t dataAddr;
	logic dataCycle;

	assign immWord = {{(`CPU_WORD_W-`CPU_IMM_W){1'b0}}, imm};
	assign dataCycle = (phase == EXEC) && (memRead || memWrite);

	// Data address from dst, src or immediate
	assign dataAddr = addrFromDst ? dstData : (addrFromSrc ? srcData : immWord);
	assign addrBus = dataCycle ? dataAddr : pc;

	assign dataOut = srcData;
	assign memWe = memWrite && (phase == EXEC);

	always_comb begin
		case (wbSel)
			WB_IMM: wbData = immWord;
			WB_MEM: wbData = dataIn;
			default: wbData = aluOut;
		endcase
	end

endmodule

/* design/cpuCore.sv */
`timescale 1ns/100ps

module cpuCore
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	output word_t addrBus,
	input word_t dataIn,
	output word_t dataOut,
	output logic memWe
);

	phase_t phase;
	word_t pc;
	regIdx_t regDst;
	regIdx_t regSrc;
	logic regWe;
	logic flagWe;
	opcode_t aluOp;
	wbSel_t wbSel;
	logic memWrite;
	logic memRead;
	logic addrFromDst;
	logic addrFromSrc;
	imm_t imm;
	word_t dstData;
	word_t srcData;
	word_t aluOut;
	word_t wbData;
	logic cFlag;
	logic zFlag;

	// Fetch, decode and program counter
	instrDecoder decoder (
		.clk(clk), .rst(rst), .dataIn(dataIn),
		.cFlag(cFlag), .zFlag(zFlag), .srcData(srcData),
		.phase(phase), .pc(pc), .regDst(regDst), .regSrc(regSrc),
		.regWe(regWe), .flagWe(flagWe), .aluOp(aluOp), .wbSel(wbSel),
		.memWrite(memWrite), .addrFromDst(addrFromDst),
		.addrFromSrc(addrFromSrc), .memRead(memRead), .imm(imm)
	);

	registerFile regFile (
		.clk(clk), .rst(rst), .regWe(regWe),
		.regDst(regDst), .regSrc(regSrc), .wbData(wbData),
		.dstData(dstData), .srcData(srcData)
	);

	alu aluUnit (
		.clk(clk), .rst(rst), .aluOp(aluOp), .flagWe(flagWe),
		.dstData(dstData), .srcData(srcData),
		.aluOut(aluOut), .cFlag(cFlag), .zFlag(zFlag)
	);

	// Bus side and write-back mux
	memPort port (
		.phase(phase), .pc(pc), .imm(imm),
		.memRead(memRead), .memWrite(memWrite),
		.addrFromDst(addrFromDst), .addrFromSrc(addrFromSrc),
		.wbSel(wbSel), .dstData(dstData), .srcData(srcData),
		.aluOut(aluOut), .dataIn(dataIn),
		.addrBus(addrBus), .dataOut(dataOut), .wbData(wbData), .memWe(memWe)
	);

endmodule

/* sim/cpu_asserts.sv */
`timescale 1ns/100ps

module cpuAsserts
	import cpu_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic memWe,
	input phase_t phase
);

	// Failures so far, watched by the testbench
	int failCount = 0;

	property noStoreInFetch;
		@(posedge clk) disable iff (rst) (phase == FETCH) |-> !memWe;
	endproperty

	// Stores never come back to back
	property noBackToBackStore;
		@(posedge clk) disable iff (rst) memWe |=> !memWe;
	endproperty

	property phaseAlternates;
		@(posedge clk) disable iff (rst) (phase == FETCH) |=> (phase == EXEC);
	endproperty

	property execReturnsToFetch;
		@(posedge clk) disable iff (rst) (phase == EXEC) |=> (phase == FETCH);
	endproperty

	property quietInReset;
		@(posedge clk) rst |-> !memWe;
	endproperty

	assert property (noStoreInFetch) else begin
		$error("memWe high during fetch");
		failCount++;
	end
	assert property (noBackToBackStore) else begin
		$error("memWe high on two cycles in a row");
		failCount++;
	end
	assert property (phaseAlternates) else begin
		$error("fetch not followed by execute");
		failCount++;
	end
	assert property (execReturnsToFetch) else begin
		$error("execute not followed by fetch");
		failCount++;
	end
	assert property (quietInReset) else begin
		$error("memWe high during reset");
		failCount++;
	end

endmodule

bind cpuCore cpuAsserts busChecks (
	.clk(clk),
	.rst(rst),
	.memWe(memWe),
	.phase(phase)
);

/* sim/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb
	import cpu_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_PROGRAMS = 20;
	localparam int NUM_INSTR = 200;
	localparam int MEM_WORDS = 256;
	localparam logic [31:0] SEED = 32'h84efb918;
	localparam longint TIMEOUT_NS =
		longint'(NUM_PROGRAMS) * (NUM_INSTR * 2 + RESET_CYCLES + 10) * CLK_PERIOD + 2000;

	logic clk;
	logic rst;
	word_t addrBus;
	word_t dataIn;
	word_t dataOut;
	logic memWe;

	// Memory as the DUT sees it
	word_t busMem [MEM_WORDS];

	// Instruction-set model state
	word_t modelMem [MEM_WORDS];
	word_t modelReg [4];
	word_t modelPc;
	logic modelC;
	logic modelZ;
	word_t modelInstr;

	cpuCore uut (
		.clk(clk),
		.rst(rst),
		.addrBus(addrBus),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.memWe(memWe)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic checkValue(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("FAILED %s expected %h got %h", name, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Same random image for the bus memory and the model
	task automatic fillMemory();
		word_t w;
		for (int i = 0; i < MEM_WORDS; i++) begin
			w = word_t'($urandom);
			busMem[i] = w;
			modelMem[i] = w;
		end
	endtask

	task automatic resetModel();
		for (int i = 0; i < 4; i++)
			modelReg[i] = '0;
		modelPc = '0;
		modelC = 1'b0;
		modelZ = 1'b0;
	endtask

	task automatic resetCore();
		@(posedge clk);
		rst <= 1'b1;
		fillMemory();
		resetModel();
		@(negedge clk);
		checkValue("memWe", word_t'(0), word_t'(memWe));
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		dataIn <= busMem[0];
	endtask

	// Flag-setting result of opcodes 0 to 6
	task automatic writeResult(input logic [1:0] idx, input word_t value, input logic carry);
		modelReg[idx] = value;
		modelC = carry;
		modelZ = (value == 16'h0000);
	endtask

	function automatic logic isStoreOp(input word_t instr);
		return (instr[15:12] == OP_ST) || (instr[15:12] == OP_STA);
	endfunction

	// Bus address the model expects during execute
	function automatic word_t execAddress(input word_t instr);
		case (instr[15:12])
			OP_LD: return modelReg[instr[9:8]];
			OP_ST: return modelReg[instr[11:10]];
			OP_LDA, OP_STA: return {8'h00, instr[7:0]};
			default: return modelPc;
		endcase
	endfunction

	task automatic executeModel();
		logic [3:0] op;
		logic [1:0] d;
		logic [1:0] s;
		word_t a;
		word_t b;
		word_t immWord;
		logic [16:0] sum;
		op = modelInstr[15:12];
		d = modelInstr[11:10];
		s = modelInstr[9:8];
		a = modelReg[d];
		b = modelReg[s];
		immWord = {8'h00, modelInstr[7:0]};
		modelPc = modelPc + 16'd1;
		case (op)
			OP_ADD: begin
				sum = {1'b0, a} + {1'b0, b};
				writeResult(d, sum[15:0], sum[16]);
			end
			OP_SUB: writeResult(d, a - b, a < b);
			OP_AND: writeResult(d, a & b, 1'b0);
			OP_OR: writeResult(d, a | b, 1'b0);
			OP_XOR: writeResult(d, a ^ b, 1'b0);
			OP_SHL: writeResult(d, {a[14:0], 1'b0}, a[15]);
			OP_SHR: writeResult(d, {1'b0, a[15:1]}, a[0]);
			OP_MOV: modelReg[d] = b;
			OP_LDI: modelReg[d] = immWord;
			OP_LD: modelReg[d] = modelMem[b[7:0]];
			OP_ST: modelMem[a[7:0]] = b;
			OP_LDA: modelReg[d] = modelMem[modelInstr[7:0]];
			OP_STA: modelMem[modelInstr[7:0]] = b;
			OP_JMP: modelPc = modelInstr[10] ? b : immWord;
			OP_JZ: if (modelZ) modelPc = immWord;
			OP_JC: if (modelC) modelPc = immWord;
		endcase
	endtask

	// One fetch and one execute cycle, entered right after the fetch edge
	task automatic runInstruction();
		word_t expAddr;
		logic isStore;
		logic storeSeen;
		logic [7:0] storeAddr;
		word_t storeData;
		@(negedge clk);
		checkValue("addrBus", modelPc, addrBus);
		checkValue("memWe", word_t'(0), word_t'(memWe));

		@(posedge clk);
		modelInstr = modelMem[modelPc[7:0]];
		expAddr = execAddress(modelInstr);
		isStore = isStoreOp(modelInstr);
		// Loads need the data word in this same cycle
		dataIn <= busMem[expAddr[7:0]];

		@(negedge clk);
		checkValue("addrBus", expAddr, addrBus);
		checkValue("memWe", word_t'(isStore), word_t'(memWe));
		if (isStore)
			checkValue("dataOut", modelReg[modelInstr[9:8]], dataOut);
		storeSeen = memWe;
		storeAddr = addrBus[7:0];
		storeData = dataOut;

		@(posedge clk);
		if (storeSeen)
			busMem[storeAddr] = storeData;
		executeModel();
		dataIn <= busMem[modelPc[7:0]];
	endtask

	initial begin
		int unsigned seedDummy;
		rst = 1'b1;
		dataIn = '0;
		seedDummy = $urandom(SEED);
		for (int p = 0; p < NUM_PROGRAMS; p++) begin
			resetCore();
			for (int n = 0; n < NUM_INSTR; n++)
				runInstruction();
		end
		@(negedge clk);
		$display(">>> PASS");
		$finish;
	end

	// Bound bus assertions count their failures
	initial begin
		wait (uut.busChecks.failCount != 0);
		$display("A bus assertion on the core failed");
		$display(">>> FAIL");
		$fatal(1, "Assertion failure");
	end

	// Watchdog sized from programs, instructions and reset length
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the CPU test run did not complete in the expected time");
		$display(">>> FAIL");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* project.f */
+incdir+design
design/cpu_pkg.sv
design/instrDecoder.sv
design/registerFile.sv
design/alu.sv
design/memPort.sv
design/cpuCore.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu_core
  description: "Two-cycle 16-bit load/store CPU core"

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/instrDecoder.sv
      - design/registerFile.sv
      - design/alu.sv
      - design/memPort.sv
      - design/cpuCore.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/cpu_asserts.sv
      - sim/cpu_tb.sv
